// File: verilog/enigma_pkg.sv
// shared widths, code word layout and column permutation rule, imported by every cipher block
`default_nettype none

package enigma_pkg;

    //==========================================================
    // widths and sizes
    //==========================================================
    // one code word
    localparam int CODE_W      = 6;
    // group field and column field
    localparam int GROUP_W     = 3;
    // entries in one rotor
    localparam int ROTOR_DEPTH = 64;
    // rotor A then rotor B
    localparam int LOAD_LEN    = 128;

    typedef logic [CODE_W-1:0]  code_t;
    typedef logic [GROUP_W-1:0] col_t;

    // same six bits, seen as a table index or as group plus column
    typedef union packed {
        code_t whole;
        struct packed {
            col_t group;
            col_t column;
        } fields;
    } code_word_u;

    //==========================================================
    // rotor B column reorder
    //==========================================================
    // row per rotation select
    // entry d names the old position that lands at position d
    localparam col_t perm_table [1 << GROUP_W][1 << GROUP_W] = '{
        '{0, 1, 2, 3, 4, 5, 6, 7},
        '{1, 0, 3, 2, 5, 4, 7, 6},
        '{2, 3, 0, 1, 6, 7, 4, 5},
        '{0, 4, 5, 6, 1, 2, 3, 7},
        '{4, 5, 6, 7, 0, 1, 2, 3},
        '{5, 6, 7, 3, 4, 0, 1, 2},
        '{6, 7, 3, 2, 5, 4, 0, 1},
        '{7, 6, 5, 4, 3, 2, 1, 0}
    };

endpackage

`default_nettype wire

// File: verilog/rotor_store.sv
// holds both rotor tables, loaded by shifting, with table lookups and reverse searches
`timescale 1ns/1ps
`default_nettype none

module rotor_store
    import enigma_pkg::*;
(
    input  logic  clk,
    // load stream
    input  logic  load_valid,
    input  code_t load_code,
    // forward lookups
    input  code_t a_index,
    output code_t a_value,
    input  code_t b_index,
    output code_t b_value,
    // reverse searches
    input  code_t a_search,
    output code_t a_hit,
    input  code_t b_search,
    output code_t b_hit
);

    //==========================================================
    // table storage
    //==========================================================
    // lower half rotor A, upper half rotor B
    code_t store [LOAD_LEN];

    // new code enters at the top, older codes move down
    // after a full load the first code sits at entry 0
    always_ff @(posedge clk) begin
        if (load_valid) begin
            for (int i = 0; i < LOAD_LEN - 1; i++) begin
                store[i] <= store[i + 1];
            end
            store[LOAD_LEN - 1] <= load_code;
        end
    end

    //==========================================================
    // forward lookups
    //==========================================================
    // rotor A straight from the lower half
    assign a_value = store[a_index];

    // rotor B offset into the upper half
    assign b_value = store[ROTOR_DEPTH + int'(b_index)];

    //==========================================================
    // reverse searches
    //==========================================================
    // scan from the top down so the lowest matching index wins
    // with permutation tables exactly one entry matches
    // no match falls back to the last index
    always_comb begin
        a_hit = code_t'(ROTOR_DEPTH - 1);
        b_hit = code_t'(ROTOR_DEPTH - 1);
        for (int i = ROTOR_DEPTH - 1; i >= 0; i--) begin
            // rotor A compare
            if (store[i] == a_search) begin
                a_hit = code_t'(i);
            end
            // rotor B compare, same index space as A
            if (store[ROTOR_DEPTH + i] == b_search) begin
                b_hit = code_t'(i);
            end
        end
    end

endmodule

`default_nettype wire

// File: verilog/column_permuter.sv
// rotor B column order state, stepped per code, with forward map and reverse column search
`timescale 1ns/1ps
`default_nettype none

module column_permuter
    import enigma_pkg::*;
(
    input  logic clk,
    input  logic rst_n,
    // advance the order, identity when low
    input  logic step,
    input  col_t rot_sel,
    // forward column map
    input  col_t column_in,
    output col_t column_out,
    // reverse column map
    input  col_t column_search,
    output col_t column_hit
);

    //==========================================================
    // column positions
    //==========================================================
    // pos[j] is the physical column used for logical column j
    col_t pos [1 << GROUP_W];

    // reorder pos per the selected permutation row
    // fall back to identity between strings
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int d = 0; d < (1 << GROUP_W); d++) begin
                pos[d] <= col_t'(d);
            end
        end else if (step) begin
            for (int d = 0; d < (1 << GROUP_W); d++) begin
                pos[d] <= pos[perm_table[rot_sel][d]];
            end
        end else begin
            for (int d = 0; d < (1 << GROUP_W); d++) begin
                pos[d] <= col_t'(d);
            end
        end
    end

    //==========================================================
    // forward map
    //==========================================================
    // logical column of rotor A output to rotor B column
    assign column_out = pos[column_in];

    //==========================================================
    // reverse map
    //==========================================================
    // find j with pos[j] equal to the searched column
    // pos is always a permutation so one j matches
    always_comb begin
        column_hit = col_t'((1 << GROUP_W) - 1);
        for (int j = (1 << GROUP_W) - 1; j >= 0; j--) begin
            if (pos[j] == column_search) begin
                column_hit = col_t'(j);
            end
        end
    end

endmodule

`default_nettype wire

// File: verilog/cipher_datapath.sv
// cipher pipeline control, mode capture, input stage, offset register and output register
`timescale 1ns/1ps
`default_nettype none

module cipher_datapath
    import enigma_pkg::*;
(
    input  logic  clk,
    input  logic  rst_n,
    input  logic  in_valid,
    input  logic  in_valid_2,
    input  logic  crypt_mode,
    input  code_t code_in,
    // rotor store lookups
    output code_t a_index,
    input  code_t a_value,
    output code_t b_index,
    input  code_t b_value,
    output code_t a_search,
    input  code_t a_hit,
    output code_t b_search,
    input  code_t b_hit,
    // column permuter maps
    output col_t  column_in,
    input  col_t  column_out,
    output col_t  column_search,
    input  col_t  column_hit,
    output logic  step,
    output col_t  rot_sel,
    // result
    output logic  out_valid,
    output code_t out_code
);

    logic       in_valid_d;
    logic       mode;
    logic       s1_valid;
    code_t      s1_code;
    // rotor A offset
    code_t      k;
    logic [1:0] k_step;
    code_word_u a_word;
    code_word_u b_idx_word;
    code_word_u ib_word;
    code_word_u ia_word;
    // reflector output
    code_t      r;
    code_t      result;

    //==========================================================
    // mode capture
    //==========================================================
    // sample crypt_mode on the first cycle of a load
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            in_valid_d <= 1'b0;
            mode       <= 1'b0;
        end else begin
            in_valid_d <= in_valid;
            if (in_valid && !in_valid_d) begin
                mode <= crypt_mode;
            end
        end
    end

    //==========================================================
    // stage 1
    //==========================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            s1_valid <= 1'b0;
        end else begin
            s1_valid <= in_valid_2;
        end
    end

    // raw code word, held only while a string is streaming
    always_ff @(posedge clk) begin
        if (in_valid_2) begin
            s1_code <= code_in;
        end
    end

    //==========================================================
    // cipher chain
    //==========================================================
    // rotor A shifted back by the offset
    assign a_index = s1_code - k;

    always_comb begin
        // rotor A output split into group and column
        a_word.whole              = a_value;
        // rotor B keeps the group, column goes through the permuter
        b_idx_word.fields.group   = a_word.fields.group;
        b_idx_word.fields.column  = column_out;
        // reflector mirrors the code space
        r                         = code_t'(ROTOR_DEPTH - 1) - b_value;
        // rotor B inverse, then undo the column permutation
        ib_word.whole             = b_hit;
        ia_word.fields.group      = ib_word.fields.group;
        ia_word.fields.column     = column_hit;
    end

    assign column_in     = a_word.fields.column;
    assign b_index       = b_idx_word.whole;
    assign b_search      = r;
    assign column_search = ib_word.fields.column;
    assign a_search      = ia_word.whole;

    // rotor A inverse, shift forward again
    assign result = a_hit + k;

    //==========================================================
    // rotor state stepping
    //==========================================================
    // decrypt steps from the return path so it mirrors encrypt
    assign k_step  = mode ? ia_word.whole[1:0] : a_value[1:0];
    assign rot_sel = mode ? r[GROUP_W-1:0] : b_value[GROUP_W-1:0];
    assign step    = s1_valid;

    // offset advances per code, clears once the string is gone
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            k <= '0;
        end else if (s1_valid) begin
            k <= k + code_t'(k_step);
        end else begin
            k <= '0;
        end
    end

    //==========================================================
    // output register
    //==========================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
            out_code  <= '0;
        end else begin
            out_valid <= s1_valid;
            out_code  <= s1_valid ? result : '0;
        end
    end

endmodule

`default_nettype wire

// File: verilog/enigma_top.sv
// cipher top level, connects rotor store, column permuter and datapath to the host pins
`timescale 1ns/1ps
`default_nettype none

module enigma_top
    import enigma_pkg::*;
(
    input  logic  clk,
    input  logic  rst_n,
    input  logic  in_valid,
    input  logic  in_valid_2,
    input  logic  crypt_mode,
    input  code_t code_in,
    output logic  out_valid,
    output code_t out_code
);

    // store lookups
    code_t a_index;
    code_t a_value;
    code_t b_index;
    code_t b_value;
    code_t a_search;
    code_t a_hit;
    code_t b_search;
    code_t b_hit;
    // column map
    col_t  column_in;
    col_t  column_out;
    col_t  column_search;
    col_t  column_hit;
    logic  step;
    col_t  rot_sel;

    //==========================================================
    // rotor tables, loaded straight from the host stream
    //==========================================================
    rotor_store store_i (
        .clk        (clk),
        .load_valid (in_valid),
        .load_code  (code_in),
        .a_index    (a_index),
        .a_value    (a_value),
        .b_index    (b_index),
        .b_value    (b_value),
        .a_search   (a_search),
        .a_hit      (a_hit),
        .b_search   (b_search),
        .b_hit      (b_hit)
    );

    // rotor B column order
    column_permuter perm_i (
        .clk           (clk),
        .rst_n         (rst_n),
        .step          (step),
        .rot_sel       (rot_sel),
        .column_in     (column_in),
        .column_out    (column_out),
        .column_search (column_search),
        .column_hit    (column_hit)
    );

    // pipeline and control
    cipher_datapath dp_i (
        .clk           (clk),
        .rst_n         (rst_n),
        .in_valid      (in_valid),
        .in_valid_2    (in_valid_2),
        .crypt_mode    (crypt_mode),
        .code_in       (code_in),
        .a_index       (a_index),
        .a_value       (a_value),
        .b_index       (b_index),
        .b_value       (b_value),
        .a_search      (a_search),
        .a_hit         (a_hit),
        .b_search      (b_search),
        .b_hit         (b_hit),
        .column_in     (column_in),
        .column_out    (column_out),
        .column_search (column_search),
        .column_hit    (column_hit),
        .step          (step),
        .rot_sel       (rot_sel),
        .out_valid     (out_valid),
        .out_code      (out_code)
    );

endmodule

`default_nettype wire

// File: testbench/enigma_asserts.sv
// pin level protocol checks for the cipher top level, attached to enigma_top with bind
`timescale 1ns/1ps
`default_nettype none

module enigma_asserts
    import enigma_pkg::*;
(
    input logic  clk,
    input logic  rst_n,
    input logic  in_valid,
    input logic  in_valid_2,
    input logic  out_valid,
    input code_t out_code
);

    // failed checks so far, watched from the testbench
    int   fail_count = 0;
    // high once the host has driven anything
    logic input_seen;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            input_seen <= 1'b0;
        end else if (in_valid || in_valid_2) begin
            input_seen <= 1'b1;
        end
    end

    //==========================================================
    // output checks
    //==========================================================
    // quiet outputs until the first host input
    idle_after_reset: assert property (@(posedge clk) disable iff (!rst_n)
        !input_seen |-> (!out_valid && out_code == '0))
    else begin
        $error("outputs not idle after reset");
        fail_count++;
    end

    // two cycle latency from in_valid_2 to out_valid
    valid_latency: assert property (@(posedge clk) disable iff (!rst_n)
        out_valid == $past(in_valid_2, 2))
    else begin
        $error("out_valid does not follow in_valid_2 by two cycles");
        fail_count++;
    end

    // no stale code on the output
    code_zero_when_idle: assert property (@(posedge clk) disable iff (!rst_n)
        !out_valid |-> out_code == '0)
    else begin
        $error("out_code nonzero while out_valid is low");
        fail_count++;
    end

    // host side, load and code phases never overlap
    one_phase_at_a_time: assert property (@(posedge clk) disable iff (!rst_n)
        !(in_valid && in_valid_2))
    else begin
        $error("in_valid and in_valid_2 high together");
        fail_count++;
    end

endmodule

bind enigma_top enigma_asserts asserts_i (
    .clk        (clk),
    .rst_n      (rst_n),
    .in_valid   (in_valid),
    .in_valid_2 (in_valid_2),
    .out_valid  (out_valid),
    .out_code   (out_code)
);

`default_nettype wire

// File: testbench/enigma_tb.sv
// testbench for the cipher top level that loads random rotors and checks strings against a model
`timescale 1ns/1ps
`default_nettype none

module enigma_tb
    import enigma_pkg::*;
();

    localparam int MAX_CYCLES = 2000;
    localparam int STR_LEN    = 40;

    logic  clk;
    logic  rst_n;
    logic  in_valid;
    logic  in_valid_2;
    logic  crypt_mode;
    code_t code_in;
    logic  out_valid;
    code_t out_code;

    // model rotors and their inverse tables
    code_t rot_a [ROTOR_DEPTH];
    code_t rot_b [ROTOR_DEPTH];
    code_t inv_a [ROTOR_DEPTH];
    code_t inv_b [ROTOR_DEPTH];
    code_t str_codes [STR_LEN];
    // expected codes from the model, read once per out_valid
    code_t exp_mem [256];
    int    exp_wr = 0;
    int    exp_rd = 0;
    int    cycles = 0;

    enigma_top dut_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .in_valid   (in_valid),
        .in_valid_2 (in_valid_2),
        .crypt_mode (crypt_mode),
        .code_in    (code_in),
        .out_valid  (out_valid),
        .out_code   (out_code)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    //==========================================================
    // checking
    //==========================================================
    out_matches_model: assert property (@(posedge clk) disable iff (!rst_n)
        out_valid |-> (exp_rd < exp_wr) && (out_code == exp_mem[exp_rd]))
    else begin
        $display("Fail %0t: out_code %0d, model expects %0d", $time,
                 $sampled(out_code), $sampled(exp_mem[exp_rd]));
        $display("Done: errors found");
        $fatal(1, "output mismatch");
    end

    // advance the expected fifo once per result
    always @(posedge clk) begin
        if (out_valid) begin
            exp_rd <= exp_rd + 1;
        end
    end

    // bound protocol checks and the run limit
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (dut_i.asserts_i.fail_count != 0) begin
            $display("A protocol check in the bound assertions failed");
            $display("Done: errors found");
            $fatal(1, "protocol check failed");
        end else if (cycles >= MAX_CYCLES) begin
            $display("Timeout: the run did not finish within %0d cycles", MAX_CYCLES);
            $display("Done: errors found");
            $fatal(1, "timeout");
        end
    end

    //==========================================================
    // stimulus and model
    //==========================================================
    // shuffle 0..63 so every reverse search has one match
    task automatic draw_tables();
        code_t tmp;
        int    j;
        for (int i = 0; i < ROTOR_DEPTH; i++) begin
            rot_a[i] = code_t'(i);
            rot_b[i] = code_t'(i);
        end
        for (int i = ROTOR_DEPTH - 1; i > 0; i--) begin
            j        = $urandom % (i + 1);
            tmp      = rot_a[i];
            rot_a[i] = rot_a[j];
            rot_a[j] = tmp;
            j        = $urandom % (i + 1);
            tmp      = rot_b[i];
            rot_b[i] = rot_b[j];
            rot_b[j] = tmp;
        end
        for (int i = 0; i < ROTOR_DEPTH; i++) begin
            inv_a[rot_a[i]] = code_t'(i);
            inv_b[rot_b[i]] = code_t'(i);
        end
        for (int n = 0; n < STR_LEN; n++) begin
            str_codes[n] = code_t'($urandom);
        end
    endtask

    // rotor A then rotor B
    // mode only on the first load cycle and its inverse after that
    task automatic load_rotors(input logic mode);
        for (int i = 0; i < LOAD_LEN; i++) begin
            @(posedge clk);
            #2;
            in_valid   = 1'b1;
            crypt_mode = (i == 0) ? mode : !mode;
            code_in    = (i < ROTOR_DEPTH) ? rot_a[i] : rot_b[i - ROTOR_DEPTH];
        end
        @(posedge clk);
        #2;
        in_valid   = 1'b0;
        crypt_mode = 1'b0;
        code_in    = '0;
    endtask

    // walk the string through the cipher rule from a cleared rotor state
    task automatic predict_string(input logic mode);
        code_t k;
        col_t  pos [8];
        col_t  nxt [8];
        code_t a;
        code_t b;
        code_t r;
        code_t ib;
        code_t ia;
        col_t  col;
        col_t  sel;
        k = '0;
        for (int d = 0; d < 8; d++) begin
            pos[d] = col_t'(d);
        end
        for (int n = 0; n < STR_LEN; n++) begin
            a  = rot_a[code_t'(str_codes[n] - k)];
            b  = rot_b[{a[5:3], pos[a[2:0]]}];
            r  = code_t'(63) - b;
            ib = inv_b[r];
            col = '0;
            for (int j = 0; j < 8; j++) begin
                if (pos[j] == ib[2:0]) begin
                    col = col_t'(j);
                end
            end
            ia = {ib[5:3], col};
            exp_mem[exp_wr] = code_t'(inv_a[ia] + k);
            exp_wr++;
            // decrypt steps from the return path
            k   = mode ? code_t'(k + ia[1:0]) : code_t'(k + a[1:0]);
            sel = mode ? r[2:0] : b[2:0];
            for (int d = 0; d < 8; d++) begin
                nxt[d] = pos[perm_table[sel][d]];
            end
            pos = nxt;
        end
    endtask

    // one back to back string followed by a drain and a short gap
    task automatic send_string();
        for (int n = 0; n < STR_LEN; n++) begin
            @(posedge clk);
            #2;
            in_valid_2 = 1'b1;
            code_in    = str_codes[n];
        end
        @(posedge clk);
        #2;
        in_valid_2 = 1'b0;
        code_in    = '0;
        while (exp_rd != exp_wr) begin
            @(posedge clk);
        end
        repeat (4) @(posedge clk);
    endtask

    initial begin
        void'($urandom(40));
        rst_n      = 1'b0;
        in_valid   = 1'b0;
        in_valid_2 = 1'b0;
        crypt_mode = 1'b0;
        code_in    = '0;
        repeat (16) @(posedge clk);
        #2;
        rst_n = 1'b1;
        repeat (4) @(posedge clk);

        // encrypt load and string
        draw_tables();
        load_rotors(1'b0);
        predict_string(1'b0);
        send_string();
        // same string again from a cleared rotor state
        predict_string(1'b0);
        send_string();
        // decrypt load with fresh tables
        draw_tables();
        load_rotors(1'b1);
        predict_string(1'b1);
        send_string();

        if (exp_wr == 3 * STR_LEN && exp_rd == exp_wr) begin
            $display("Done: no errors");
            $finish;
        end else begin
            $display("Only %0d of %0d results came out", exp_rd, exp_wr);
            $display("Done: errors found");
            $fatal(1, "missing results");
        end
    end

endmodule

`default_nettype wire

// File: enigma_top.f
verilog/enigma_pkg.sv
verilog/rotor_store.sv
verilog/column_permuter.sv
verilog/cipher_datapath.sv
verilog/enigma_top.sv
testbench/enigma_asserts.sv
testbench/enigma_tb.sv
